//--- Bender.yml
package:
  name: execUnit

sources:
  - files:
      - hw/execPkg.sv
      - hw/operandIf.sv
      - hw/aluUnit.sv
      - hw/mulUnit.sv
      - hw/execControl.sv
      - hw/execTop.sv
  - target: test
    files:
      - tb/execTb.sv

//--- hw/aluUnit.sv
`default_nettype none

module aluUnit (
	operandIf.alu opBus,
	output execPkg::word_t aluResult,
	output logic aluNeq,
	output logic aluLt
);

	logic subSel;
	execPkg::word_t notB;
	execPkg::word_t addIn;
	execPkg::word_t sum;
	execPkg::word_t diff;
	execPkg::word_t andOut;
	execPkg::word_t orOut;
	logic signDiffer;
	logic [execPkg::shiftWidth-1:0] shAmt;
	execPkg::word_t sllStage [execPkg::shiftWidth+1];
	execPkg::word_t sraStage [execPkg::shiftWidth+1];

	// add and subtract share one adder that takes B inverted with carry in for subtract
	assign subSel = (opBus.op == execPkg::opSub);
	assign notB = ~opBus.opB;
	assign addIn = subSel ? notB : opBus.opB;
	assign sum = opBus.opA + addIn + execPkg::word_t'(subSel);

	assign andOut = opBus.opA & opBus.opB;
	assign orOut = opBus.opA | opBus.opB;

	// upper bits of B are ignored for shifts
	assign shAmt = opBus.opB[execPkg::shiftWidth-1:0];

	assign sllStage[0] = opBus.opA;
	assign sraStage[0] = opBus.opA;

	// stage i moves the word by 2**i when bit i of the amount is set
	for (genvar i = 0; i < execPkg::shiftWidth; i++) begin : gShift
		assign sllStage[i+1] = shAmt[i]
			? {sllStage[i][execPkg::dataWidth-1-2**i:0], {(2**i){1'b0}}}
			: sllStage[i];
		assign sraStage[i+1] = shAmt[i]
			? {{(2**i){sraStage[i][execPkg::dataWidth-1]}},
				sraStage[i][execPkg::dataWidth-1:2**i]}
			: sraStage[i];
	end

	always_comb begin
		case (opBus.op)
			execPkg::opAdd: aluResult = sum;
			execPkg::opSub: aluResult = sum;
			execPkg::opAnd: aluResult = andOut;
			execPkg::opOr: aluResult = orOut;
			execPkg::opSll: aluResult = sllStage[execPkg::shiftWidth];
			execPkg::opSra: aluResult = sraStage[execPkg::shiftWidth];
			default: aluResult = '0; // multiply result comes from mulUnit
		endcase
	end

	// the comparator always subtracts, whatever the opcode selects above
	assign diff = opBus.opA + notB + execPkg::word_t'(1'b1);
	assign signDiffer = opBus.opA[execPkg::dataWidth-1] ^ opBus.opB[execPkg::dataWidth-1];

	assign aluNeq = |diff;

	// with equal signs the difference cannot overflow, so its sign decides
	assign aluLt = signDiffer ? opBus.opA[execPkg::dataWidth-1]
		: diff[execPkg::dataWidth-1];

endmodule

`default_nettype wire

//--- hw/execControl.sv
`default_nettype none

module execControl (
	input logic clk,
	input logic rst,
	input logic start,
	input execPkg::aluOp_t op,
	input execPkg::word_t opA,
	input execPkg::word_t opB,
	operandIf.ctrl opBus,
	input execPkg::word_t aluResult,
	input logic aluNeq,
	input logic aluLt,
	input execPkg::word_t product,
	output logic step,
	output execPkg::word_t result,
	output logic neq,
	output logic lt,
	output logic done,
	output logic busy
);

	execPkg::ctrlState_t state;
	logic opValid;
	logic accept;
	logic mulKick;
	logic [execPkg::mulSteps-1:0] stepCnt;

	assign opValid = (op <= execPkg::opMul);
	assign accept = !busy && start && opValid; // starts while busy are dropped

	assign busy = (state != execPkg::stIdle);
	assign done = (state == execPkg::stDone);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= execPkg::stIdle;
		end else begin
			case (state)
				execPkg::stIdle: begin
					if (accept) begin
						state <= (op == execPkg::opMul) ? execPkg::stMul : execPkg::stAlu;
					end
				end
				execPkg::stMul: begin
					if (stepCnt[execPkg::mulSteps-1]) begin
						state <= execPkg::stAlu; // last step happens on this edge
					end
				end
				execPkg::stAlu: begin
					state <= execPkg::stDone;
				end
				default: begin
					state <= execPkg::stIdle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			opBus.load <= 1'b0;
		end else begin
			opBus.load <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			opBus.op <= op;
			opBus.opA <= opA;
			opBus.opB <= opB;
		end
	end

	// the token enters together with the multiplier load and walks one bit per edge
	assign mulKick = opBus.load && (state == execPkg::stMul);

	always_ff @(posedge clk) begin
		if (rst) begin
			stepCnt <= '0;
		end else begin
			stepCnt <= {stepCnt[execPkg::mulSteps-2:0], mulKick};
		end
	end

	assign step = |stepCnt;

	// both paths finish through stAlu, where the latched op picks the source
	always_ff @(posedge clk) begin
		if (rst) begin
			result <= '0;
			neq <= 1'b0;
			lt <= 1'b0;
		end else if (state == execPkg::stAlu) begin
			result <= (opBus.op == execPkg::opMul) ? product : aluResult;
			neq <= aluNeq;
			lt <= aluLt;
		end
	end

endmodule

`default_nettype wire

//--- hw/execPkg.sv
`default_nettype none

package execPkg;

	// datapath widths

	localparam int dataWidth = 32;
	localparam int shiftWidth = 5; // shift amount comes from the low bits of operand B

	// one multiply iteration per multiplier bit
	localparam int mulSteps = 32; // also the length of the one-hot step counter

	typedef logic [dataWidth-1:0] word_t;

	// opcode values are also the result select codes
	typedef enum logic [2:0] {
		opAdd = 3'd0,
		opSub = 3'd1,
		opAnd = 3'd2,
		opOr = 3'd3,
		opSll = 3'd4,
		opSra = 3'd5,
		opMul = 3'd6 // code 7 is left unused and is rejected at start
	} aluOp_t;

	typedef enum logic [1:0] {
		stIdle,
		stAlu, // the multiply also ends in this capture state once its steps are over
		stMul,
		stDone
	} ctrlState_t;

endpackage

`default_nettype wire

//--- hw/execTop.sv
`default_nettype none

module execTop (
	input logic clk,
	input logic rst,
	input logic start,
	input execPkg::aluOp_t op,
	input execPkg::word_t opA,
	input execPkg::word_t opB,
	output execPkg::word_t result,
	output logic neq,
	output logic lt,
	output logic done,
	output logic busy
);

	execPkg::word_t aluResult;
	execPkg::word_t product;
	logic aluNeq;
	logic aluLt;
	logic step;

	operandIf opBus ();

	execControl control (
		.clk(clk),
		.rst(rst),
		.start(start),
		.op(op),
		.opA(opA),
		.opB(opB),
		.opBus(opBus.ctrl),
		.aluResult(aluResult),
		.aluNeq(aluNeq),
		.aluLt(aluLt),
		.product(product),
		.step(step),
		.result(result),
		.neq(neq),
		.lt(lt),
		.done(done),
		.busy(busy)
	);

	aluUnit alu (
		.opBus(opBus.alu),
		.aluResult(aluResult),
		.aluNeq(aluNeq),
		.aluLt(aluLt)
	);

	mulUnit mul (
		.clk(clk),
		.rst(rst),
		.opBus(opBus.mul),
		.step(step),
		.product(product)
	);

endmodule

`default_nettype wire

//--- hw/mulUnit.sv
`default_nettype none

module mulUnit (
	input logic clk,
	input logic rst,
	operandIf.mul opBus,
	input logic step,
	output execPkg::word_t product
);

	execPkg::word_t acc;
	execPkg::word_t mcand;
	execPkg::word_t mplier;
	execPkg::word_t partial;

	// add the multiplicand only where the current multiplier bit is one
	assign partial = mplier[0] ? mcand : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			acc <= '0;
		end else if (opBus.load) begin
			acc <= '0;
		end else if (step) begin
			acc <= acc + partial; // carries past the top bit are dropped
		end
	end

	always_ff @(posedge clk) begin
		if (opBus.load) begin
			mcand <= opBus.opA;
			mplier <= opBus.opB;
		end else if (step) begin
			mcand <= {mcand[execPkg::dataWidth-2:0], 1'b0};
			mplier <= {1'b0, mplier[execPkg::dataWidth-1:1]};
		end
	end

	// valid once mulSteps steps have run after the load
	assign product = acc;

endmodule

`default_nettype wire

//--- hw/operandIf.sv
`default_nettype none

interface operandIf;

	execPkg::word_t opA;
	execPkg::word_t opB;
	execPkg::aluOp_t op;
	logic load; // one cycle after an accepted start

	modport ctrl (
		output opA,
		output opB,
		output op,
		output load
	);

	modport alu (
		input opA,
		input opB,
		input op
	);

	modport mul (
		input opA,
		input opB,
		input load
	);

endinterface

`default_nettype wire

//--- list.f
hw/execPkg.sv
hw/operandIf.sv
hw/aluUnit.sv
hw/mulUnit.sv
hw/execControl.sv
hw/execTop.sv
tb/execTb.sv

//--- tb/execTb.sv
`default_nettype none

module execTb;

	localparam int maxOps = 64;
	localparam int fieldsPerOp = 6; // opcode, opA, opB, result, neq, lt
	localparam int timeoutCycles = 100;

	logic clk;
	logic rst;
	logic start;
	execPkg::aluOp_t op;
	execPkg::word_t opA;
	execPkg::word_t opB;
	execPkg::word_t result;
	logic neq;
	logic lt;
	logic done;
	logic busy;

	logic [31:0] traceMem [0:maxOps*fieldsPerOp-1];
	int traceLine;
	int opCount;
	int doneCount;
	int expectedDones;

	execTop UUT (
		.clk(clk),
		.rst(rst),
		.start(start),
		.op(op),
		.opA(opA),
		.opB(opB),
		.result(result),
		.neq(neq),
		.lt(lt),
		.done(done),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// every done pulse is counted, so a stray one shows up at the end
	always @(negedge clk) begin
		if (rst) begin
			doneCount <= 0;
		end else if (done === 1'b1) begin
			doneCount <= doneCount + 1;
		end
	end

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input execPkg::word_t got,
			input execPkg::word_t expected);
		assert (got === expected) else begin
			reportFailure($sformatf("ERROR: %s = 0x%08h, expected 0x%08h at trace entry %0d",
				name, got, expected, traceLine));
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic expected);
		assert (got === expected) else begin
			reportFailure($sformatf("ERROR: %s = 0x%h, expected 0x%h at trace entry %0d",
				name, got, expected, traceLine));
		end
	endtask

	// start cycle, load edge, one edge per step and the capture edge
	function automatic int expectedLatency(input logic [2:0] code);
		if (code == execPkg::opMul) begin
			return execPkg::mulSteps + 3;
		end
		return 2;
	endfunction

	task automatic runOperation(input logic [2:0] code, input execPkg::word_t a,
			input execPkg::word_t b, input execPkg::word_t expResult,
			input logic expNeq, input logic expLt, input logic pokeWhileBusy);
		int edges;
		@(posedge clk);
		start <= 1'b1;
		op <= execPkg::aluOp_t'(code);
		opA <= a;
		opB <= b;
		@(posedge clk); // start is accepted on this edge
		start <= pokeWhileBusy; // a second start that must be ignored
		op <= execPkg::opAdd;
		opA <= ~a;
		opB <= ~b;
		@(negedge clk);
		checkBit("busy", busy, 1'b1);
		edges = 0;
		while (done !== 1'b1 && edges < timeoutCycles) begin
			@(posedge clk);
			start <= 1'b0;
			edges++;
			@(negedge clk);
			checkBit("busy", busy, 1'b1);
		end
		if (done !== 1'b1) begin
			reportFailure($sformatf(
				"operation at trace entry %0d (opcode %0d) never raised done within %0d cycles",
				traceLine, code, timeoutCycles));
		end
		checkWord("done latency", execPkg::word_t'(edges + 1),
			execPkg::word_t'(expectedLatency(code)));
		checkWord("result", result, expResult);
		checkBit("neq", neq, expNeq);
		checkBit("lt", lt, expLt);
		@(negedge clk);
		checkBit("done", done, 1'b0); // done lasts one cycle only
		checkBit("busy", busy, 1'b0);
		checkWord("result", result, expResult);
	endtask

	// opcode 7 must leave the unit idle and the outputs untouched
	task automatic tryInvalidStart(input execPkg::word_t a, input execPkg::word_t b,
			input execPkg::word_t expResult, input logic expNeq, input logic expLt);
		@(posedge clk);
		start <= 1'b1;
		op <= execPkg::aluOp_t'(3'd7);
		opA <= a;
		opB <= b;
		@(posedge clk);
		start <= 1'b0;
		op <= execPkg::opAdd;
		repeat (4) begin
			@(negedge clk);
			checkBit("busy", busy, 1'b0);
			checkBit("done", done, 1'b0);
		end
		checkWord("result", result, expResult);
		checkBit("neq", neq, expNeq);
		checkBit("lt", lt, expLt);
	endtask

	initial begin
		int gap;
		int base;
		void'($urandom(32'h8534));
		rst = 1'b1;
		start = 1'b0;
		op = execPkg::opAdd;
		opA = '0;
		opB = '0;
		traceLine = 0;
		expectedDones = 0;

		// anything above 7 in an opcode slot marks the end of the trace
		for (int k = 0; k < maxOps*fieldsPerOp; k++) begin
			traceMem[k] = 32'hEE000000 | k;
		end
		$readmemh("tb/execTrace.txt", traceMem);
		opCount = 0;
		while (opCount < maxOps && traceMem[opCount*fieldsPerOp] <= 32'd7) begin
			opCount++;
		end
		if (opCount == 0) begin
			reportFailure("the trace file tb/execTrace.txt holds no operations");
		end

		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		checkBit("done", done, 1'b0);
		checkBit("busy", busy, 1'b0);
		checkWord("result", result, '0);
		checkBit("neq", neq, 1'b0);
		checkBit("lt", lt, 1'b0);

		for (int i = 0; i < opCount; i++) begin
			base = i*fieldsPerOp;
			traceLine = i + 1;
			gap = $urandom % 4;
			repeat (gap) @(posedge clk);
			if (traceMem[base][2:0] == 3'd7) begin
				tryInvalidStart(traceMem[base+1], traceMem[base+2], traceMem[base+3],
					traceMem[base+4][0], traceMem[base+5][0]);
			end else begin
				runOperation(traceMem[base][2:0], traceMem[base+1], traceMem[base+2],
					traceMem[base+3], traceMem[base+4][0], traceMem[base+5][0], i[0]);
				expectedDones++;
			end
		end

		@(posedge clk);
		@(negedge clk);
		checkWord("done count", execPkg::word_t'(doneCount), execPkg::word_t'(expectedDones));
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/execTrace.txt
// columns, all hex: opcode opA opB result neq lt
// opcode 7 is rejected, so its result columns repeat the values still held
7 00000011 00000022 00000000 0 0
0 00000005 00000003 00000008 1 0
0 FFFFFFFF 00000001 00000000 1 1
0 7FFFFFFF 00000001 80000000 1 0
0 80000000 80000000 00000000 0 0
0 12345678 9ABCDEF0 ACF13568 1 0
1 00000003 00000005 FFFFFFFE 1 1
1 80000000 00000001 7FFFFFFF 1 1
1 7FFFFFFF FFFFFFFF 80000000 1 0
1 0000ABCD 0000ABCD 00000000 0 0
1 00000000 80000000 80000000 1 0
2 F0F0F0F0 0FF00FF0 00F000F0 1 1
2 FFFFFFFF 80000001 80000001 1 0
3 F0F0F0F0 0FF00FF0 FFF0FFF0 1 1
3 00000000 00000000 00000000 0 0
4 87654321 00000000 87654321 1 1
4 87654321 00000001 0ECA8642 1 1
4 0000ABCD 00000010 ABCD0000 1 0
4 00000001 0000001F 80000000 1 1
4 00000003 FFFFFFE1 00000006 1 0
5 80000000 0000001F FFFFFFFF 1 1
5 7FFFFFFF 0000001F 00000000 1 0
5 F0000000 00000010 FFFFF000 1 1
5 12345678 00000001 091A2B3C 1 0
5 87654321 00000000 87654321 1 1
5 C0000000 00000021 E0000000 1 1
7 00000001 00000002 E0000000 1 1
6 00000007 00000006 0000002A 1 0
6 FFFFFFFF 00000005 FFFFFFFB 1 1
6 00000000 12345678 00000000 1 1
6 FFFFFFFE FFFFFFFD 00000006 1 0
6 00010000 00010000 00000000 0 0
6 12345678 00000010 23456780 1 0
6 80000000 80000000 00000000 0 0
6 0000FFFF 0000FFFF FFFE0001 0 0
0 7FFFFFFF 80000000 FFFFFFFF 1 0
1 80000000 7FFFFFFF 00000001 1 1
7 FFFFFFFF FFFFFFFF 00000001 1 1
